/* all.f */
common/rv_decode_pkg.sv
decode/instr_field_extract.sv
decode/instr_ctrl_decode.sv
decode/decode_out_stage.sv
rtl/rv_decode_top.sv
verification/rv_decode_props.sv
verification/tb_rv_decode.sv

/* common/rv_decode_pkg.sv */
`default_nettype none

package rv_decode_pkg;

    // widths with a meaning of their own
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [4:0]  opcode_t;
    typedef logic [1:0]  imm_sel_t;
    typedef logic [1:0]  op1_sel_t;

    // major opcodes, taken from instr[6:2]
    localparam opcode_t opc_load   = 5'b00000;
    localparam opcode_t opc_op_imm = 5'b00100;
    localparam opcode_t opc_auipc  = 5'b00101;
    localparam opcode_t opc_store  = 5'b01000;
    localparam opcode_t opc_op     = 5'b01100;
    localparam opcode_t opc_lui    = 5'b01101;
    localparam opcode_t opc_branch = 5'b11000;
    localparam opcode_t opc_jalr   = 5'b11001;
    localparam opcode_t opc_jal    = 5'b11011;
    localparam opcode_t opc_system = 5'b11100;

    // funct7 forms, alt selects sub and arithmetic shift
    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;

    // source of the main immediate slot
    localparam imm_sel_t imm_sel_i = 2'd0;
    localparam imm_sel_t imm_sel_s = 2'd1;
    localparam imm_sel_t imm_sel_u = 2'd2;

    // first alu operand
    localparam op1_sel_t op1_reg  = 2'd0;
    localparam op1_sel_t op1_pc   = 2'd1;
    localparam op1_sel_t op1_zero = 2'd2;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_pkt_t;

    // raw slices of the word, independent of the instruction kind
    typedef struct packed {
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        funct3_t  funct3;
        word_t    imm_i;
        word_t    imm_s;
        word_t    imm_b;
        word_t    imm_u;
        word_t    imm_j;
    } fields_t;

    typedef struct packed {
        // operation groups
        logic cmp;
        logic bits;
        logic shift;
        logic arith;
        // operations within a group
        logic cmp_eq;
        logic cmp_lts;
        logic cmp_ltu;
        logic cmp_inversed;
        logic bits_and;
        logic bits_or;
        logic bits_xor;
        logic arith_shl;
        logic arith_shr;
        logic arith_sub;
        logic arith_add;
        logic shift_arithmetical;
    } alu_ctrl_t;

    typedef struct packed {
        logic      inst_load;
        logic      inst_store;
        logic      inst_branch;
        logic      inst_jal;
        logic      inst_jalr;
        logic      inst_ebreak;
        logic      reg_write;
        logic      supported;
        imm_sel_t  imm_sel;
        op1_sel_t  op1_sel;
        logic      op2_r;
        logic      op2_i;
        logic      op2_j;
        logic      res_alu;
        logic      res_memory;
        logic      res_pc_p4;
        alu_ctrl_t alu_ctrl;
        funct3_t   funct3_out;
    } ctrl_t;

    // record handed to the execute stage
    typedef struct packed {
        word_t     pc;
        word_t     pc_p4;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        funct3_t   funct3;
        word_t     imm_i;
        word_t     imm_j;
        logic      inst_load;
        logic      inst_store;
        logic      inst_branch;
        logic      inst_jal;
        logic      inst_jalr;
        logic      inst_ebreak;
        logic      reg_write;
        logic      supported;
        op1_sel_t  op1_sel;
        logic      op2_r;
        logic      op2_i;
        logic      op2_j;
        logic      res_alu;
        logic      res_memory;
        logic      res_pc_p4;
        alu_ctrl_t alu_ctrl;
    } decode_pkt_t;

endpackage

`default_nettype wire

/* decode/decode_out_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_out_stage (
    input  wire                             i_clk,
    input  wire                             i_rst_n,
    input  wire                             i_valid,
    input  wire rv_decode_pkg::fetch_pkt_t  i_fetch,
    input  wire rv_decode_pkg::fields_t     i_fields,
    input  wire rv_decode_pkg::ctrl_t       i_ctrl,
    output logic                            o_ready,
    output rv_decode_pkg::decode_pkt_t      o_dec,
    output logic                            o_valid,
    input  wire                             i_ready
);

    import rv_decode_pkg::*;

    decode_pkt_t dec_d;
    word_t       imm_main;
    logic        accept;

    // one-entry register, free when empty or being drained
    assign o_ready = ~o_valid | i_ready;
    assign accept  = i_valid & o_ready;

    always_comb begin
        case (i_ctrl.imm_sel)
            imm_sel_u: imm_main = i_fields.imm_u;
            imm_sel_s: imm_main = i_fields.imm_s;
            default:   imm_main = i_fields.imm_i;
        endcase
    end

    always_comb begin
        dec_d.pc     = i_fetch.pc;
        dec_d.pc_p4  = i_fetch.pc + 32'd4;
        dec_d.rd     = i_fields.rd;
        // lui adds its immediate to zero
        dec_d.rs1    = (i_ctrl.op1_sel == op1_zero) ? '0 : i_fields.rs1;
        dec_d.rs2    = i_fields.rs2;
        dec_d.funct3 = i_ctrl.funct3_out;
        dec_d.imm_i  = imm_main;
        // branch offset shares the slot with the jal offset
        dec_d.imm_j  = i_ctrl.inst_jal ? i_fields.imm_j : i_fields.imm_b;

        dec_d.inst_load   = i_ctrl.inst_load;
        dec_d.inst_store  = i_ctrl.inst_store;
        dec_d.inst_branch = i_ctrl.inst_branch;
        dec_d.inst_jal    = i_ctrl.inst_jal;
        dec_d.inst_jalr   = i_ctrl.inst_jalr;
        dec_d.inst_ebreak = i_ctrl.inst_ebreak;
        dec_d.reg_write   = i_ctrl.reg_write;
        dec_d.supported   = i_ctrl.supported;
        dec_d.op1_sel     = i_ctrl.op1_sel;
        dec_d.op2_r       = i_ctrl.op2_r;
        dec_d.op2_i       = i_ctrl.op2_i;
        dec_d.op2_j       = i_ctrl.op2_j;
        dec_d.res_alu     = i_ctrl.res_alu;
        dec_d.res_memory  = i_ctrl.res_memory;
        dec_d.res_pc_p4   = i_ctrl.res_pc_p4;
        dec_d.alu_ctrl    = i_ctrl.alu_ctrl;
    end

    // payload, loaded on accept only
    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_dec <= dec_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (accept) begin
            o_valid <= 1'b1;
        end else if (i_ready) begin
            o_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* decode/instr_ctrl_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_ctrl_decode (
    input  wire rv_decode_pkg::word_t   i_instr,
    output rv_decode_pkg::ctrl_t        o_ctrl
);

    import rv_decode_pkg::*;

    opcode_t     opcode;
    funct3_t     funct3;
    logic [6:0]  funct7;
    logic [11:0] funct12;
    logic        inst_full;
    logic        inst_none;
    logic        f7_base;
    logic        f7_alt;

    // opcode hits, only for full 32-bit words
    logic is_load, is_imm, is_auipc, is_store, is_reg;
    logic is_lui, is_branch, is_jalr, is_jal, is_system;

    logic inst_load, inst_store, inst_branch, inst_jalr, inst_jal;
    logic inst_ecall, inst_ebreak, inst_lui, inst_auipc;
    logic inst_addi, inst_slli, inst_slti, inst_sltiu, inst_xori;
    logic inst_srli, inst_srai, inst_ori, inst_andi;
    logic inst_add, inst_sub, inst_sll, inst_slt, inst_sltu;
    logic inst_xor, inst_srl, inst_sra, inst_or, inst_and;
    logic inst_imm, inst_reg;
    logic src_imm;

    assign opcode    = i_instr[6:2];
    assign funct3    = i_instr[14:12];
    assign funct7    = i_instr[31:25];
    assign funct12   = i_instr[31:20];
    assign inst_full = (i_instr[1:0] == 2'b11);
    assign inst_none = ~(|i_instr);
    assign f7_base   = (funct7 == funct7_base);
    assign f7_alt    = (funct7 == funct7_alt);

    assign is_load   = inst_full & (opcode == opc_load);
    assign is_imm    = inst_full & (opcode == opc_op_imm);
    assign is_auipc  = inst_full & (opcode == opc_auipc);
    assign is_store  = inst_full & (opcode == opc_store);
    assign is_reg    = inst_full & (opcode == opc_op);
    assign is_lui    = inst_full & (opcode == opc_lui);
    assign is_branch = inst_full & (opcode == opc_branch);
    assign is_jalr   = inst_full & (opcode == opc_jalr);
    assign is_jal    = inst_full & (opcode == opc_jal);
    assign is_system = inst_full & (opcode == opc_system);

    // lb lh lw lbu lhu
    assign inst_load   = is_load & (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
    // sb sh sw
    assign inst_store  = is_store & (funct3 inside {3'b000, 3'b001, 3'b010});
    // funct3 010 and 011 are reserved for branches
    assign inst_branch = is_branch & (funct3[2:1] != 2'b01);
    assign inst_jalr   = is_jalr & (funct3 == 3'b000);
    assign inst_jal    = is_jal;
    assign inst_lui    = is_lui;
    assign inst_auipc  = is_auipc;
    assign inst_ecall  = is_system & (funct3 == 3'b000) & (funct12 == 12'h000);
    assign inst_ebreak = is_system & (funct3 == 3'b000) & (funct12 == 12'h001);

    // immediate arithmetic, shifts check funct7 as well
    assign inst_addi  = is_imm & (funct3 == 3'b000);
    assign inst_slli  = is_imm & (funct3 == 3'b001) & f7_base;
    assign inst_slti  = is_imm & (funct3 == 3'b010);
    assign inst_sltiu = is_imm & (funct3 == 3'b011);
    assign inst_xori  = is_imm & (funct3 == 3'b100);
    assign inst_srli  = is_imm & (funct3 == 3'b101) & f7_base;
    assign inst_srai  = is_imm & (funct3 == 3'b101) & f7_alt;
    assign inst_ori   = is_imm & (funct3 == 3'b110);
    assign inst_andi  = is_imm & (funct3 == 3'b111);

    // register arithmetic
    assign inst_add  = is_reg & (funct3 == 3'b000) & f7_base;
    assign inst_sub  = is_reg & (funct3 == 3'b000) & f7_alt;
    assign inst_sll  = is_reg & (funct3 == 3'b001) & f7_base;
    assign inst_slt  = is_reg & (funct3 == 3'b010) & f7_base;
    assign inst_sltu = is_reg & (funct3 == 3'b011) & f7_base;
    assign inst_xor  = is_reg & (funct3 == 3'b100) & f7_base;
    assign inst_srl  = is_reg & (funct3 == 3'b101) & f7_base;
    assign inst_sra  = is_reg & (funct3 == 3'b101) & f7_alt;
    assign inst_or   = is_reg & (funct3 == 3'b110) & f7_base;
    assign inst_and  = is_reg & (funct3 == 3'b111) & f7_base;

    assign inst_imm = |{inst_addi, inst_slli, inst_slti, inst_sltiu, inst_xori,
                        inst_srli, inst_srai, inst_ori, inst_andi};
    assign inst_reg = |{inst_add, inst_sub, inst_sll, inst_slt, inst_sltu,
                        inst_xor, inst_srl, inst_sra, inst_or, inst_and};

    // operand 2 comes from an immediate
    assign src_imm = |{inst_jalr, inst_load, inst_imm, inst_lui, inst_auipc, inst_store};

    assign o_ctrl.inst_load   = inst_load;
    assign o_ctrl.inst_store  = inst_store;
    assign o_ctrl.inst_branch = inst_branch;
    assign o_ctrl.inst_jal    = inst_jal;
    assign o_ctrl.inst_jalr   = inst_jalr;
    assign o_ctrl.inst_ebreak = inst_ebreak;

    // the all-zero word passes as a bubble
    assign o_ctrl.supported = |{inst_none, inst_load, inst_store, inst_branch, inst_jal,
                                inst_jalr, inst_lui, inst_auipc, inst_imm, inst_reg,
                                inst_ecall, inst_ebreak};
    assign o_ctrl.reg_write = |{inst_load, inst_imm, inst_reg, inst_lui, inst_auipc,
                                inst_jal, inst_jalr};

    assign o_ctrl.imm_sel = (inst_lui | inst_auipc) ? imm_sel_u :
                            inst_store              ? imm_sel_s : imm_sel_i;
    assign o_ctrl.op1_sel = (inst_auipc | inst_jal) ? op1_pc :
                            inst_lui                ? op1_zero : op1_reg;

    assign o_ctrl.op2_j = inst_jal;
    assign o_ctrl.op2_i = src_imm;
    assign o_ctrl.op2_r = ~(inst_jal | src_imm);

    assign o_ctrl.res_memory = inst_load;
    assign o_ctrl.res_pc_p4  = inst_jal | inst_jalr;
    assign o_ctrl.res_alu    = ~(inst_load | inst_jal | inst_jalr);

    // alu group and operation
    assign o_ctrl.alu_ctrl.cmp   = |{inst_branch, inst_slti, inst_sltiu, inst_slt, inst_sltu};
    assign o_ctrl.alu_ctrl.bits  = |{inst_andi, inst_and, inst_ori, inst_or, inst_xori, inst_xor};
    assign o_ctrl.alu_ctrl.shift = |{inst_slli, inst_sll, inst_srli, inst_srl, inst_srai, inst_sra};
    assign o_ctrl.alu_ctrl.arith = |{inst_add, inst_addi, inst_sub, inst_load, inst_store};

    assign o_ctrl.alu_ctrl.cmp_eq  = inst_branch & (funct3[2:1] == 2'b00);
    assign o_ctrl.alu_ctrl.cmp_lts = inst_slti | inst_slt | (inst_branch & (funct3[2:1] == 2'b10));
    assign o_ctrl.alu_ctrl.cmp_ltu = inst_sltiu | inst_sltu | (inst_branch & (funct3[2:1] == 2'b11));
    // bne, bge and bgeu test the opposite condition
    assign o_ctrl.alu_ctrl.cmp_inversed = inst_branch & funct3[0];

    assign o_ctrl.alu_ctrl.bits_and  = inst_andi | inst_and;
    assign o_ctrl.alu_ctrl.bits_or   = inst_ori | inst_or;
    assign o_ctrl.alu_ctrl.bits_xor  = inst_xori | inst_xor;
    assign o_ctrl.alu_ctrl.arith_shl = inst_slli | inst_sll;
    assign o_ctrl.alu_ctrl.arith_shr = |{inst_srli, inst_srl, inst_srai, inst_sra};
    assign o_ctrl.alu_ctrl.arith_sub = inst_sub;
    assign o_ctrl.alu_ctrl.arith_add = |{inst_add, inst_addi, inst_load, inst_store};
    assign o_ctrl.alu_ctrl.shift_arithmetical = inst_srai | inst_sra;

    // word access size when the slot holds no full instruction
    assign o_ctrl.funct3_out = inst_full ? funct3 : 3'b010;

endmodule

`default_nettype wire

/* decode/instr_field_extract.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_field_extract (
    input  wire rv_decode_pkg::word_t   i_instr,
    output rv_decode_pkg::fields_t      o_fields
);

    // register indices and funct3 sit at fixed positions in every format
    assign o_fields.rd     = i_instr[11:7];
    assign o_fields.rs1    = i_instr[19:15];
    assign o_fields.rs2    = i_instr[24:20];
    assign o_fields.funct3 = i_instr[14:12];

    // I format, bits 31..20
    assign o_fields.imm_i = {
        {21{i_instr[31]}},
        i_instr[30:20]
    };

    // S format, upper part in 31..25 and lower part in the rd slot
    assign o_fields.imm_s = {
        {21{i_instr[31]}},
        i_instr[30:25],
        i_instr[11:7]
    };

    // B format, halfword offset
    assign o_fields.imm_b = {
        {20{i_instr[31]}},
        i_instr[7],
        i_instr[30:25],
        i_instr[11:8],
        1'b0
    };

    // U format, low twelve bits cleared
    assign o_fields.imm_u = {
        i_instr[31:12],
        12'b0
    };

    // J format, bits scattered as in the spec
    assign o_fields.imm_j = {
        {12{i_instr[31]}},
        i_instr[19:12],
        i_instr[20],
        i_instr[30:21],
        1'b0
    };

endmodule

`default_nettype wire

/* rtl/rv_decode_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_decode_top (
    input  wire                             i_clk,
    input  wire                             i_rst_n,
    input  wire                             i_valid,
    input  wire rv_decode_pkg::fetch_pkt_t  i_fetch,
    output logic                            o_ready,
    output rv_decode_pkg::decode_pkt_t      o_dec,
    output logic                            o_valid,
    input  wire                             i_ready
);

    import rv_decode_pkg::*;

    fields_t fields;
    ctrl_t   ctrl;

    // both decoders look at the same incoming word
    instr_field_extract instr_field_extract_inst (
        .i_instr  (i_fetch.instr),
        .o_fields (fields)
    );

    instr_ctrl_decode instr_ctrl_decode_inst (
        .i_instr (i_fetch.instr),
        .o_ctrl  (ctrl)
    );

    // merge and register
    decode_out_stage decode_out_stage_inst (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (i_valid),
        .i_fetch  (i_fetch),
        .i_fields (fields),
        .i_ctrl   (ctrl),
        .o_ready  (o_ready),
        .o_dec    (o_dec),
        .o_valid  (o_valid),
        .i_ready  (i_ready)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert --top-module tb_rv_decode -f all.f \
    --Mdir "$OBJ" -o sim_rv_decode
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"$OBJ/sim_rv_decode" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
exit 0

/* verification/rv_decode_props.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_decode_props (
    input wire                             i_clk,
    input wire                             i_rst_n,
    input wire                             i_valid,
    input wire                             i_ready,
    input wire                             o_ready,
    input wire                             o_valid,
    input wire rv_decode_pkg::decode_pkt_t o_dec
);

    // empty during reset and on the edge after it
    reset_clears_valid: assert property (
        @(posedge i_clk) !i_rst_n |=> !o_valid
    ) else $error("o_valid high after a reset cycle");

    // a stalled record stays put
    stall_holds_output: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_valid && !i_ready |=> o_valid && $stable(o_dec)
    ) else $error("o_dec or o_valid changed while the output was stalled");

    ready_rule: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_ready == (!o_valid || i_ready)
    ) else $error("o_ready does not follow the empty-or-draining rule");

    // accepted packet shows up on the next edge
    accept_fills: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_valid && o_ready |=> o_valid
    ) else $error("accepted packet did not reach the output register");

endmodule

bind rv_decode_top rv_decode_props rv_decode_props_inst (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_valid (i_valid),
    .i_ready (i_ready),
    .o_ready (o_ready),
    .o_valid (o_valid),
    .o_dec   (o_dec)
);

`default_nettype wire

/* verification/tb_rv_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rv_decode;

    import rv_decode_pkg::*;

    logic        i_clk = 1'b0;
    logic        i_rst_n = 1'b0;
    logic        i_valid = 1'b0;
    fetch_pkt_t  i_fetch = '0;
    logic        i_ready = 1'b0;
    logic        o_ready;
    decode_pkt_t o_dec;
    logic        o_valid;

    word_t      rng;
    word_t      tmpl [44];
    fetch_pkt_t exp_q[$];
    int         acc_q[$];
    int         cyc = 0;
    int         n_checks = 0;
    int         n_errors = 0;
    bit         hold_ready;
    bit         timed_out;

    rv_decode_top rv_decode_top_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .i_fetch (i_fetch),
        .o_ready (o_ready),
        .o_dec   (o_dec),
        .o_valid (o_valid),
        .i_ready (i_ready)
    );

    always #5 i_clk = ~i_clk;

    function automatic word_t next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // fixed bits per table group, the rest is random
    function automatic word_t fixed_bits(logic [5:0] k);
        if (k < 6'd4) return 32'h0000_007F;
        if (k < 6'd25) return 32'h0000_707F;
        if (k < 6'd39) return 32'hFE00_707F;
        if (k < 6'd41) return 32'h0000_0003;
        return 32'hFFFF_FFFF;
    endfunction

    function automatic word_t pick_instr();
        word_t      r;
        logic [5:0] k;
        r = next_rand();
        k = 6'(next_rand() % 44);
        return (r & ~fixed_bits(k)) | (tmpl[k] & fixed_bits(k));
    endfunction

    // expected record from the RV32I encoding rules
    function automatic decode_pkt_t ref_decode(fetch_pkt_t f);
        decode_pkt_t d;
        word_t       w;
        logic [2:0]  f3;
        logic        full, alt, ld, st, br, jal, jalr, lui, auipc, sys, opi, opr, ar;
        w = f.instr;
        f3 = w[14:12];
        full = (w[1:0] == 2'b11);
        alt = (w[31:25] == 7'h20);
        ld = full && w[6:2] == opc_load && f3 != 3'd3 && f3 < 3'd6;
        st = full && w[6:2] == opc_store && f3 < 3'd3;
        br = full && w[6:2] == opc_branch && f3[2:1] != 2'b01;
        jal = full && w[6:2] == opc_jal;
        jalr = full && w[6:2] == opc_jalr && f3 == 3'd0;
        lui = full && w[6:2] == opc_lui;
        auipc = full && w[6:2] == opc_auipc;
        // ecall and ebreak differ only in funct12 bit 0
        sys = full && w[6:2] == opc_system && f3 == 3'd0 && w[31:21] == 11'd0;
        opi = full && w[6:2] == opc_op_imm && ((f3 == 3'd1) ? (w[31:25] == 7'h00)
            : (f3 != 3'd5 || w[31:25] == 7'h00 || alt));
        opr = full && w[6:2] == opc_op
            && (w[31:25] == 7'h00 || (alt && (f3 == 3'd0 || f3 == 3'd5)));
        ar = opi || opr;
        d = '0;
        d.pc = f.pc;
        d.pc_p4 = f.pc + 32'd4;
        d.rd = w[11:7];
        d.rs1 = lui ? 5'd0 : w[19:15];
        d.rs2 = w[24:20];
        d.funct3 = full ? f3 : 3'd2;
        d.imm_i = (lui || auipc) ? {w[31:12], 12'h000}
            : (st ? {{20{w[31]}}, w[31:25], w[11:7]} : {{20{w[31]}}, w[31:20]});
        d.imm_j = jal ? {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0}
            : {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        d.inst_load = ld;
        d.inst_store = st;
        d.inst_branch = br;
        d.inst_jal = jal;
        d.inst_jalr = jalr;
        d.inst_ebreak = sys && w[20];
        d.reg_write = ld || ar || lui || auipc || jal || jalr;
        d.supported = d.reg_write || st || br || sys || w == 32'd0;
        d.op1_sel = (auipc || jal) ? op1_pc : (lui ? op1_zero : op1_reg);
        d.op2_j = jal;
        d.op2_i = jalr || ld || opi || lui || auipc || st;
        d.op2_r = !(d.op2_j || d.op2_i);
        d.res_memory = ld;
        d.res_pc_p4 = jal || jalr;
        d.res_alu = !(ld || jal || jalr);
        d.alu_ctrl.cmp = br || (ar && f3[2:1] == 2'b01);
        d.alu_ctrl.bits = ar && f3[2] && f3 != 3'd5;
        d.alu_ctrl.shift = ar && f3[1:0] == 2'b01;
        d.alu_ctrl.arith = ld || st || (ar && f3 == 3'd0);
        d.alu_ctrl.cmp_eq = br && f3[2:1] == 2'b00;
        d.alu_ctrl.cmp_lts = (ar && f3 == 3'd2) || (br && f3[2:1] == 2'b10);
        d.alu_ctrl.cmp_ltu = (ar && f3 == 3'd3) || (br && f3[2:1] == 2'b11);
        d.alu_ctrl.cmp_inversed = br && f3[0];
        d.alu_ctrl.bits_and = ar && f3 == 3'd7;
        d.alu_ctrl.bits_or = ar && f3 == 3'd6;
        d.alu_ctrl.bits_xor = ar && f3 == 3'd4;
        d.alu_ctrl.arith_shl = ar && f3 == 3'd1;
        d.alu_ctrl.arith_shr = ar && f3 == 3'd5;
        d.alu_ctrl.arith_sub = opr && f3 == 3'd0 && alt;
        d.alu_ctrl.arith_add = ld || st || (ar && f3 == 3'd0 && !(opr && alt));
        d.alu_ctrl.shift_arithmetical = ar && f3 == 3'd5 && alt;
        return d;
    endfunction

    // scoreboard, both transfers happen on this edge
    always @(posedge i_clk) begin
        fetch_pkt_t  exp_pkt;
        decode_pkt_t exp_dec;
        int          acc;
        cyc = cyc + 1;
        if (i_rst_n && o_valid && i_ready) begin
            n_checks++;
            if (exp_q.size() == 0) begin
                $display("[FAIL] %0t: output transfer with no accepted packet", $time);
                n_errors++;
            end else begin
                exp_pkt = exp_q.pop_front();
                acc = acc_q.pop_front();
                exp_dec = ref_decode(exp_pkt);
                assert (o_dec === exp_dec) else begin
                    $display("[FAIL] %0t: instr %h got %h expected %h",
                             $time, exp_pkt.instr, o_dec, exp_dec);
                    n_errors++;
                end
                assert (!hold_ready || cyc - acc == 1) else begin
                    $display("[FAIL] %0t: pc %h out after %0d cycles, expected 1",
                             $time, exp_pkt.pc, cyc - acc);
                    n_errors++;
                end
            end
        end
        if (i_rst_n && i_valid && o_ready) begin
            exp_q.push_back(i_fetch);
            acc_q.push_back(cyc);
        end
    end

    task automatic run_stream(input int count);
        fetch_pkt_t pkt;
        word_t      r;
        int         issued;
        int         accepted;
        int         guard;
        issued = 0;
        accepted = 0;
        guard = 0;
        while (accepted < count && !timed_out) begin
            @(posedge i_clk);
            guard++;
            if (i_valid && o_ready) accepted++;
            r = next_rand();
            // a new packet only once the current one is taken
            if (!i_valid || o_ready) begin
                if (issued < count && r[0]) begin
                    pkt.pc = next_rand();
                    pkt.instr = pick_instr();
                    i_fetch <= pkt;
                    i_valid <= 1'b1;
                    issued++;
                end else begin
                    i_valid <= 1'b0;
                end
            end
            i_ready <= hold_ready || r[1] || r[2];
            if (guard > count * 20) begin
                $display("timeout: only %0d of %0d packets were accepted", accepted, count);
                timed_out = 1'b1;
            end
        end
        i_valid <= 1'b0;
    endtask

    task automatic send_fixed(input word_t fpc, input word_t finstr);
        int guard;
        guard = 0;
        @(posedge i_clk);
        i_fetch <= '{pc: fpc, instr: finstr};
        i_valid <= 1'b1;
        do begin
            @(posedge i_clk);
            guard++;
            if (guard > 20) begin
                $display("timeout: directed word %h was never accepted", finstr);
                timed_out = 1'b1;
            end
        end while (!o_ready && !timed_out);
        i_valid <= 1'b0;
    endtask

    task automatic drain();
        int guard;
        guard = 0;
        i_ready <= 1'b1;
        do begin
            @(negedge i_clk);
            guard++;
            if (guard > 50) begin
                $display("timeout: %0d packets never left the stage", exp_q.size());
                timed_out = 1'b1;
            end
        end while (exp_q.size() != 0 && !timed_out);
    endtask

    initial begin
        int errs;
        rng = 32'd53;
        hold_ready = 1'b0;
        timed_out = 1'b0;
        // lui auipc jal unused, jalr branches loads stores op_imm,
        // shifts op bad-funct7, short words, ecall ebreak zero
        tmpl = '{32'h37, 32'h17, 32'h6F, 32'h0B, 32'h67,
                 32'h63, 32'h1063, 32'h4063, 32'h5063, 32'h6063, 32'h7063,
                 32'h03, 32'h1003, 32'h2003, 32'h4003, 32'h5003,
                 32'h23, 32'h1023, 32'h2023,
                 32'h13, 32'h2013, 32'h3013, 32'h4013, 32'h6013, 32'h7013,
                 32'h1013, 32'h5013, 32'h40005013,
                 32'h33, 32'h40000033, 32'h1033, 32'h2033, 32'h3033,
                 32'h4033, 32'h5033, 32'h40005033, 32'h6033, 32'h7033,
                 32'h02000033, 32'h1, 32'h2, 32'h73, 32'h00100073, 32'h0};
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;

        errs = n_errors;
        run_stream(600);
        drain();
        $display("test random_stream: %0d errors", n_errors - errs);

        errs = n_errors;
        hold_ready = 1'b1;
        run_stream(200);
        drain();
        $display("test ready_high_latency: %0d errors", n_errors - errs);

        // pc wraparound, lui, bubble, bad funct7, ebreak
        errs = n_errors;
        send_fixed(32'hFFFF_FFFC, 32'hABCD_E0B7);
        send_fixed(32'hFFFF_FFF8, 32'h0000_0000);
        send_fixed(32'h0000_1000, 32'h0220_81B3);
        send_fixed(32'h0000_1004, 32'h0010_0073);
        drain();
        $display("test directed_words: %0d errors", n_errors - errs);

        $display("tests: 3, checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
